/* hw/cache_pkg.sv */
// Cache subsystem definitions
`default_nettype none

package cache_pkg;

    // Every bus carries a byte address and one data word
    localparam int addr_width = 32;
    localparam int word_width = 32;

    // Line count of a direct-mapped cache unless the top level says otherwise
    localparam int default_sets = 16;

    // What each side of the L1 holds
    typedef enum logic {
        pass_through,
        direct_mapped
    } cache_kind_e;

endpackage

`default_nettype wire

/* hw/pass_through_cache.sv */
// Pass-through cache
`timescale 1ns/1ps
`default_nettype none

module pass_through_cache import cache_pkg::*; (
    // Clock and reset keep the port list in line with the direct-mapped cache
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] proc_addr,
    input  logic [word_width-1:0] proc_wdata,
    input  logic                  proc_ren,
    input  logic                  proc_wen,
    output logic [word_width-1:0] proc_rdata,
    output logic                  proc_busy,
    output logic [addr_width-1:0] mem_addr,
    output logic [word_width-1:0] mem_wdata,
    output logic                  mem_ren,
    output logic                  mem_wen,
    input  logic [word_width-1:0] mem_rdata,
    input  logic                  mem_busy
);

    // Requests go out unchanged
    assign mem_addr  = proc_addr;
    assign mem_wdata = proc_wdata;
    assign mem_ren   = proc_ren;
    assign mem_wen   = proc_wen;

    // The processor waits exactly as long as memory does
    assign proc_rdata = mem_rdata;
    assign proc_busy  = mem_busy;

endmodule

`default_nettype wire

/* hw/direct_mapped_cache.sv */
// Direct-mapped write-back cache
`timescale 1ns/1ps
`default_nettype none

module direct_mapped_cache import cache_pkg::*; #(
    parameter int SETS = default_sets
) (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] proc_addr,
    input  logic [word_width-1:0] proc_wdata,
    input  logic                  proc_ren,
    input  logic                  proc_wen,
    output logic [word_width-1:0] proc_rdata,
    output logic                  proc_busy,
    output logic [addr_width-1:0] mem_addr,
    output logic [word_width-1:0] mem_wdata,
    output logic                  mem_ren,
    output logic                  mem_wen,
    input  logic [word_width-1:0] mem_rdata,
    input  logic                  mem_busy,
    input  logic                  flush,
    input  logic                  clear,
    output logic                  flush_done,
    output logic                  clear_done
);

    localparam int index_bits = $clog2(SETS);
    localparam int tag_bits   = addr_width - 2 - index_bits;

    typedef enum logic [2:0] {
        idle,
        writeback,
        fill,
        flush_scan,
        clear_scan
    } state_e;

    state_e                state;
    logic [SETS-1:0]       valid;
    logic [SETS-1:0]       dirty;
    logic [tag_bits-1:0]   tag_mem [SETS];
    logic [word_width-1:0] data_mem [SETS];
    logic [index_bits-1:0] scan_idx;
    logic [index_bits-1:0] line_idx;
    logic [tag_bits-1:0]   proc_tag;
    logic                  flush_q;
    logic                  clear_q;
    logic                  flush_pend;
    logic                  clear_pend;
    logic                  request;
    logic                  hit;
    logic                  write_hit;
    logic                  victim_dirty;
    logic                  scan_last;

    // The sweeps walk the lines by counter, everything else uses the request index
    assign line_idx = (state == flush_scan || state == clear_scan) ?
                      scan_idx : proc_addr[2 +: index_bits];
    assign proc_tag     = proc_addr[addr_width-1 -: tag_bits];
    assign request      = proc_ren || proc_wen;
    assign hit          = valid[line_idx] && (tag_mem[line_idx] == proc_tag);
    assign write_hit    = (state == idle) && proc_wen && hit;
    assign victim_dirty = valid[line_idx] && dirty[line_idx];
    assign scan_last    = scan_idx == index_bits'(SETS - 1);

    // Hits complete in the cycle they are presented
    assign proc_busy  = !((state == idle) && request && hit);
    assign proc_rdata = data_mem[line_idx];

    always_comb begin
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_addr  = {proc_addr[addr_width-1:2], 2'b00};
        mem_wdata = data_mem[line_idx];
        if (state == writeback || (state == flush_scan && victim_dirty)) begin
            // Victim address is rebuilt from the stored tag
            mem_wen  = 1'b1;
            mem_addr = {tag_mem[line_idx], line_idx, 2'b00};
        end else if (state == fill) begin
            mem_ren = 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            valid      <= '0;
            dirty      <= '0;
            scan_idx   <= '0;
            flush_q    <= 1'b0;
            clear_q    <= 1'b0;
            flush_pend <= 1'b0;
            clear_pend <= 1'b0;
            flush_done <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            flush_q    <= flush;
            clear_q    <= clear;
            flush_done <= 1'b0;
            clear_done <= 1'b0;
            // A maintenance request is remembered until the FSM is free to take it
            if (flush && !flush_q) flush_pend <= 1'b1;
            if (clear && !clear_q) clear_pend <= 1'b1;
            case (state)
                idle: begin
                    scan_idx <= '0;
                    if (write_hit) dirty[line_idx] <= 1'b1;
                    if (flush_pend) begin
                        flush_pend <= 1'b0;
                        state      <= flush_scan;
                    end else if (clear_pend) begin
                        clear_pend <= 1'b0;
                        state      <= clear_scan;
                    end else if (request && !hit) begin
                        state <= victim_dirty ? writeback : fill;
                    end
                end
                writeback: begin
                    if (!mem_busy) begin
                        dirty[line_idx] <= 1'b0;
                        state           <= fill;
                    end
                end
                fill: begin
                    // Back to idle, where the retried request hits
                    if (!mem_busy) begin
                        valid[line_idx] <= 1'b1;
                        dirty[line_idx] <= 1'b0;
                        state           <= idle;
                    end
                end
                flush_scan: begin
                    if (!victim_dirty || !mem_busy) begin
                        valid[line_idx] <= 1'b0;
                        dirty[line_idx] <= 1'b0;
                        scan_idx        <= scan_idx + 1'b1;
                        if (scan_last) begin
                            flush_done <= 1'b1;
                            state      <= idle;
                        end
                    end
                end
                clear_scan: begin
                    valid[line_idx] <= 1'b0;
                    dirty[line_idx] <= 1'b0;
                    scan_idx        <= scan_idx + 1'b1;
                    if (scan_last) begin
                        clear_done <= 1'b1;
                        state      <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Tag and data storage
    always_ff @(posedge CLK) begin
        if (state == fill && !mem_busy) begin
            tag_mem[line_idx]  <= proc_tag;
            data_mem[line_idx] <= mem_rdata;
        end else if (write_hit) begin
            data_mem[line_idx] <= proc_wdata;
        end
    end

endmodule

`default_nettype wire

/* hw/separate_caches.sv */
// Separate instruction and data caches
`timescale 1ns/1ps
`default_nettype none

module separate_caches import cache_pkg::*; #(
    parameter cache_kind_e ICACHE_KIND = pass_through,
    parameter cache_kind_e DCACHE_KIND = direct_mapped,
    parameter int          SETS        = default_sets
) (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] i_addr,
    input  logic [word_width-1:0] i_wdata,
    input  logic                  i_ren,
    input  logic                  i_wen,
    output logic [word_width-1:0] i_rdata,
    output logic                  i_busy,
    input  logic [addr_width-1:0] d_addr,
    input  logic [word_width-1:0] d_wdata,
    input  logic                  d_ren,
    input  logic                  d_wen,
    output logic [word_width-1:0] d_rdata,
    output logic                  d_busy,
    output logic [addr_width-1:0] icache_addr,
    output logic [word_width-1:0] icache_wdata,
    output logic                  icache_ren,
    output logic                  icache_wen,
    input  logic [word_width-1:0] icache_rdata,
    input  logic                  icache_busy,
    output logic [addr_width-1:0] dcache_addr,
    output logic [word_width-1:0] dcache_wdata,
    output logic                  dcache_ren,
    output logic                  dcache_wen,
    input  logic [word_width-1:0] dcache_rdata,
    input  logic                  dcache_busy,
    input  logic                  i_flush,
    input  logic                  i_clear,
    output logic                  i_flush_done,
    output logic                  i_clear_done,
    input  logic                  d_flush,
    input  logic                  d_clear,
    output logic                  d_flush_done,
    output logic                  d_clear_done
);

    generate
        case (ICACHE_KIND)
            pass_through: begin : g_icache_pt
                pass_through_cache icache (
                    .CLK(CLK), .arst_n(arst_n),
                    .proc_addr(i_addr), .proc_wdata(i_wdata),
                    .proc_ren(i_ren), .proc_wen(i_wen),
                    .proc_rdata(i_rdata), .proc_busy(i_busy),
                    .mem_addr(icache_addr), .mem_wdata(icache_wdata),
                    .mem_ren(icache_ren), .mem_wen(icache_wen),
                    .mem_rdata(icache_rdata), .mem_busy(icache_busy)
                );
                // Nothing to flush or clear, so maintenance is always finished
                assign i_flush_done = 1'b1;
                assign i_clear_done = 1'b1;
            end
            direct_mapped: begin : g_icache_dm
                direct_mapped_cache #(.SETS(SETS)) icache (
                    .CLK(CLK), .arst_n(arst_n),
                    .proc_addr(i_addr), .proc_wdata(i_wdata),
                    .proc_ren(i_ren), .proc_wen(i_wen),
                    .proc_rdata(i_rdata), .proc_busy(i_busy),
                    .mem_addr(icache_addr), .mem_wdata(icache_wdata),
                    .mem_ren(icache_ren), .mem_wen(icache_wen),
                    .mem_rdata(icache_rdata), .mem_busy(icache_busy),
                    .flush(i_flush), .clear(i_clear),
                    .flush_done(i_flush_done), .clear_done(i_clear_done)
                );
            end
        endcase
    endgenerate

    generate
        case (DCACHE_KIND)
            pass_through: begin : g_dcache_pt
                pass_through_cache dcache (
                    .CLK(CLK), .arst_n(arst_n),
                    .proc_addr(d_addr), .proc_wdata(d_wdata),
                    .proc_ren(d_ren), .proc_wen(d_wen),
                    .proc_rdata(d_rdata), .proc_busy(d_busy),
                    .mem_addr(dcache_addr), .mem_wdata(dcache_wdata),
                    .mem_ren(dcache_ren), .mem_wen(dcache_wen),
                    .mem_rdata(dcache_rdata), .mem_busy(dcache_busy)
                );
                assign d_flush_done = 1'b1;
                assign d_clear_done = 1'b1;
            end
            direct_mapped: begin : g_dcache_dm
                direct_mapped_cache #(.SETS(SETS)) dcache (
                    .CLK(CLK), .arst_n(arst_n),
                    .proc_addr(d_addr), .proc_wdata(d_wdata),
                    .proc_ren(d_ren), .proc_wen(d_wen),
                    .proc_rdata(d_rdata), .proc_busy(d_busy),
                    .mem_addr(dcache_addr), .mem_wdata(dcache_wdata),
                    .mem_ren(dcache_ren), .mem_wen(dcache_wen),
                    .mem_rdata(dcache_rdata), .mem_busy(dcache_busy),
                    .flush(d_flush), .clear(d_clear),
                    .flush_done(d_flush_done), .clear_done(d_clear_done)
                );
            end
        endcase
    endgenerate

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
// Memory port arbiter
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cache_pkg::*; (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] icache_addr,
    input  logic [word_width-1:0] icache_wdata,
    input  logic                  icache_ren,
    input  logic                  icache_wen,
    output logic [word_width-1:0] icache_rdata,
    output logic                  icache_busy,
    input  logic [addr_width-1:0] dcache_addr,
    input  logic [word_width-1:0] dcache_wdata,
    input  logic                  dcache_ren,
    input  logic                  dcache_wen,
    output logic [word_width-1:0] dcache_rdata,
    output logic                  dcache_busy,
    output logic [addr_width-1:0] mem_addr,
    output logic [word_width-1:0] mem_wdata,
    output logic                  mem_ren,
    output logic                  mem_wen,
    input  logic [word_width-1:0] mem_rdata,
    input  logic                  mem_busy
);

    typedef enum logic [1:0] {
        own_none,
        own_icache,
        own_dcache
    } owner_e;

    owner_e owner;
    owner_e grant;
    logic   icache_req;
    logic   dcache_req;

    assign icache_req = icache_ren || icache_wen;
    assign dcache_req = dcache_ren || dcache_wen;

    // A fresh grant is decided in the same cycle, data side first
    always_comb begin
        grant = owner;
        if (owner == own_none) begin
            if (dcache_req) grant = own_dcache;
            else if (icache_req) grant = own_icache;
        end
    end

    assign mem_addr  = (grant == own_dcache) ? dcache_addr : icache_addr;
    assign mem_wdata = (grant == own_dcache) ? dcache_wdata : icache_wdata;
    assign mem_ren   = (grant == own_dcache) ? dcache_ren : (grant == own_icache) && icache_ren;
    assign mem_wen   = (grant == own_dcache) ? dcache_wen : (grant == own_icache) && icache_wen;

    assign icache_rdata = mem_rdata;
    assign dcache_rdata = mem_rdata;
    assign icache_busy  = (grant == own_icache) ? mem_busy : 1'b1;
    assign dcache_busy  = (grant == own_dcache) ? mem_busy : 1'b1;

    // Ownership lasts until the granted transfer sees busy low
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            owner <= own_none;
        end else begin
            owner <= (grant != own_none && mem_busy) ? grant : own_none;
        end
    end

endmodule

`default_nettype wire

/* hw/cache_subsystem_top.sv */
// L1 cache subsystem top level
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem_top import cache_pkg::*; #(
    parameter cache_kind_e ICACHE_KIND = pass_through,
    parameter cache_kind_e DCACHE_KIND = direct_mapped,
    parameter int          SETS        = default_sets
) (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] i_addr,
    input  logic [word_width-1:0] i_wdata,
    input  logic                  i_ren,
    input  logic                  i_wen,
    output logic [word_width-1:0] i_rdata,
    output logic                  i_busy,
    input  logic [addr_width-1:0] d_addr,
    input  logic [word_width-1:0] d_wdata,
    input  logic                  d_ren,
    input  logic                  d_wen,
    output logic [word_width-1:0] d_rdata,
    output logic                  d_busy,
    output logic [addr_width-1:0] mem_addr,
    output logic [word_width-1:0] mem_wdata,
    output logic                  mem_ren,
    output logic                  mem_wen,
    input  logic [word_width-1:0] mem_rdata,
    input  logic                  mem_busy,
    input  logic                  i_flush,
    input  logic                  i_clear,
    output logic                  i_flush_done,
    output logic                  i_clear_done,
    input  logic                  d_flush,
    input  logic                  d_clear,
    output logic                  d_flush_done,
    output logic                  d_clear_done
);

    // Cache side memory buses between the caches and the arbiter
    logic [addr_width-1:0] icache_addr;
    logic [word_width-1:0] icache_wdata;
    logic                  icache_ren;
    logic                  icache_wen;
    logic [word_width-1:0] icache_rdata;
    logic                  icache_busy;
    logic [addr_width-1:0] dcache_addr;
    logic [word_width-1:0] dcache_wdata;
    logic                  dcache_ren;
    logic                  dcache_wen;
    logic [word_width-1:0] dcache_rdata;
    logic                  dcache_busy;

    separate_caches #(
        .ICACHE_KIND(ICACHE_KIND),
        .DCACHE_KIND(DCACHE_KIND),
        .SETS(SETS)
    ) caches (.*);

    mem_arbiter arbiter (.*);

endmodule

`default_nettype wire

/* test/tb_memory_model.sv */
// Behavioral backing memory
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model import cache_pkg::*; (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] addr,
    input  logic [word_width-1:0] wdata,
    input  logic                  ren,
    input  logic                  wen,
    output logic [word_width-1:0] rdata,
    output logic                  busy
);

    // 4 KiB of words, addressed by byte address bits 11 to 2
    logic [word_width-1:0] store [1024];
    logic [1:0]            wait_count;
    logic                  request;

    // Each word starts as a scrambled copy of its byte address
    initial begin
        for (int k = 0; k < 1024; k++) begin
            store[k] = (32'(k) << 2) * 32'h9e3779b1 ^ 32'h5a5a0f0f;
        end
    end

    assign request = ren || wen;

    // Two busy cycles, then one cycle in which the transfer completes
    assign busy  = !(request && wait_count == 2'd2);
    assign rdata = store[addr[11:2]];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wait_count <= '0;
        end else if (!request || !busy) begin
            wait_count <= '0;
        end else begin
            wait_count <= wait_count + 1'b1;
        end
    end

    always @(posedge CLK) begin
        if (wen && !busy) store[addr[11:2]] <= wdata;
    end

endmodule

`default_nettype wire

/* test/tb_cache_subsystem.sv */
// Cache subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem import cache_pkg::*; ();

    // The traffic below takes roughly 1000 cycles and the watchdog allows four times that
    localparam int          cycle_limit = 4000;
    localparam logic [31:0] lfsr_taps   = 32'h80200003;

    logic                  CLK;
    logic                  arst_n;
    logic [addr_width-1:0] i_addr;
    logic [word_width-1:0] i_wdata;
    logic                  i_ren;
    logic                  i_wen;
    logic [word_width-1:0] i_rdata;
    logic                  i_busy;
    logic [addr_width-1:0] d_addr;
    logic [word_width-1:0] d_wdata;
    logic                  d_ren;
    logic                  d_wen;
    logic [word_width-1:0] d_rdata;
    logic                  d_busy;
    logic [addr_width-1:0] mem_addr;
    logic [word_width-1:0] mem_wdata;
    logic                  mem_ren;
    logic                  mem_wen;
    logic [word_width-1:0] mem_rdata;
    logic                  mem_busy;
    logic                  i_flush;
    logic                  i_clear;
    logic                  i_flush_done;
    logic                  i_clear_done;
    logic                  d_flush;
    logic                  d_clear;
    logic                  d_flush_done;
    logic                  d_clear_done;

    // Processor view of every word, as the reference model sees it
    logic [word_width-1:0] ref_word [1024];
    logic [word_width-1:0] expected_i;
    logic [word_width-1:0] expected_d;
    logic [31:0]           lfsr_state;
    int                    cycles = 0;
    int                    read_errors = 0;
    int                    state_errors = 0;
    int                    flush_pulses = 0;
    int                    clear_pulses = 0;

    cache_subsystem_top #(
        .ICACHE_KIND(pass_through),
        .DCACHE_KIND(direct_mapped),
        .SETS(16)
    ) DUT (.*);

    tb_memory_model memory (
        .CLK(CLK), .arst_n(arst_n), .addr(mem_addr), .wdata(mem_wdata),
        .ren(mem_ren), .wen(mem_wen), .rdata(mem_rdata), .busy(mem_busy)
    );

    always #10 CLK = ~CLK;

    assign expected_i = ref_word[i_addr[11:2]];
    assign expected_d = ref_word[d_addr[11:2]];

    function automatic logic [31:0] initial_word(input logic [31:0] byte_addr);
        return byte_addr * 32'h9e3779b1 ^ 32'h5a5a0f0f;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? lfsr_taps : 32'h0);
        end
        return value;
    endfunction

    task automatic data_access(input logic is_write, input logic [31:0] addr,
                               input logic [31:0] data, output int waited);
        @(posedge CLK);
        d_addr  <= addr;
        d_wdata <= data;
        d_ren   <= !is_write;
        d_wen   <= is_write;
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (d_busy);
        @(posedge CLK);
        if (is_write) ref_word[addr[11:2]] = data;
        d_ren <= 1'b0;
        d_wen <= 1'b0;
    endtask

    task automatic instr_read(input logic [31:0] addr);
        @(posedge CLK);
        i_addr <= addr;
        i_ren  <= 1'b1;
        do @(negedge CLK); while (i_busy);
        @(posedge CLK);
        i_ren <= 1'b0;
    endtask

    task automatic run_maintenance(input logic do_flush);
        @(posedge CLK);
        d_flush <= do_flush;
        d_clear <= !do_flush;
        @(posedge CLK);
        d_flush <= 1'b0;
        d_clear <= 1'b0;
        do @(negedge CLK); while (!(do_flush ? d_flush_done : d_clear_done));
        repeat (2) @(negedge CLK);
    endtask

    data_read_check: assert property (@(posedge CLK) disable iff (!arst_n)
        (d_ren && !d_busy) |-> (d_rdata == expected_d))
    else begin
        $display("ERR %0t: data read at %h returned %h, expected %h", $time,
                 $sampled(d_addr), $sampled(d_rdata), $sampled(expected_d));
        read_errors++;
    end

    instr_read_check: assert property (@(posedge CLK) disable iff (!arst_n)
        (i_ren && !i_busy) |-> (i_rdata == expected_i))
    else begin
        $display("ERR %0t: instruction read at %h returned %h, expected %h", $time,
                 $sampled(i_addr), $sampled(i_rdata), $sampled(expected_i));
        read_errors++;
    end

    // The pass-through side has nothing to sweep
    instr_done_check: assert property (@(posedge CLK) disable iff (!arst_n)
        i_flush_done && i_clear_done)
    else begin
        $display("ERR %0t: instruction side done outputs went low", $time);
        state_errors++;
    end

    always @(negedge CLK) begin
        if (d_flush_done) flush_pulses++;
        if (d_clear_done) clear_pulses++;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int          waited;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] old;
        logic [31:0] fetch_addr;
        CLK = 1'b0;
        arst_n = 1'b0;
        i_addr = '0;
        i_wdata = '0;
        i_ren = 1'b0;
        i_wen = 1'b0;
        d_addr = '0;
        d_wdata = '0;
        d_ren = 1'b0;
        d_wen = 1'b0;
        i_flush = 1'b0;
        i_clear = 1'b0;
        d_flush = 1'b0;
        d_clear = 1'b0;
        lfsr_state = 32'h526c;
        for (int k = 0; k < 1024; k++) ref_word[k] = initial_word(32'(k) << 2);
        repeat (3) @(posedge CLK);
        arst_n <= 1'b1;

        // Data addresses stay below 0x800, instruction fetches above it
        for (int k = 0; k < 12; k++) begin
            data_access(1'b0, random_bits(9) << 2, '0, waited);
            instr_read(32'h800 | (random_bits(9) << 2));
        end

        // Read after write must hit in a single cycle
        for (int k = 0; k < 8; k++) begin
            a = random_bits(9) << 2;
            data_access(1'b1, a, random_bits(32), waited);
            data_access(1'b0, a, '0, waited);
            hit_check: assert (waited == 1) else begin
                $display("ERR %0t: read after write at %h took %0d cycles", $time, a, waited);
                state_errors++;
            end
        end

        // Same index, other tag, so the dirty line is written back
        a = random_bits(9) << 2;
        w = random_bits(32);
        data_access(1'b1, a, w, waited);
        data_access(1'b0, a ^ 32'h40, '0, waited);
        evict_check: assert (memory.store[a[11:2]] == w) else begin
            $display("ERR %0t: evicted word at %h not in memory", $time, a);
            state_errors++;
        end
        data_access(1'b0, a, '0, waited);

        for (int k = 0; k < 10; k++) begin
            a = random_bits(9) << 2;
            w = random_bits(32);
            data_access(1'b1, a, w, waited);
        end
        run_maintenance(1'b1);
        flush_pulse_check: assert (flush_pulses == 1) else begin
            $display("ERR %0t: flush_done pulsed %0d times", $time, flush_pulses);
            state_errors++;
        end
        for (int k = 0; k < 1024; k++) begin
            flush_mem_check: assert (memory.store[k] == ref_word[k]) else begin
                $display("ERR %0t: memory word %0d is %h after flush, expected %h", $time,
                         k, memory.store[k], ref_word[k]);
                state_errors++;
            end
        end

        // A clear drops the unflushed write so memory still holds the old word
        a = random_bits(9) << 2;
        old = ref_word[a[11:2]];
        data_access(1'b1, a, random_bits(32), waited);
        data_access(1'b0, a, '0, waited);
        run_maintenance(1'b0);
        clear_pulse_check: assert (clear_pulses == 1) else begin
            $display("ERR %0t: clear_done pulsed %0d times", $time, clear_pulses);
            state_errors++;
        end
        ref_word[a[11:2]] = old;
        data_access(1'b0, a, '0, waited);

        // Both sides at once, with maintenance poked on the instruction side
        @(posedge CLK);
        i_flush <= 1'b1;
        i_clear <= 1'b1;
        @(posedge CLK);
        i_flush <= 1'b0;
        i_clear <= 1'b0;
        for (int k = 0; k < 6; k++) begin
            fetch_addr = 32'h800 | (random_bits(9) << 2);
            a = random_bits(9) << 2;
            w = random_bits(32);
            fork
                instr_read(fetch_addr);
                data_access(k[0], a, w, waited);
            join
        end

        repeat (2) @(posedge CLK);
        $display("Error count: %0d read, %0d state", read_errors, state_errors);
        if (read_errors == 0 && state_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/cache_pkg.sv
hw/pass_through_cache.sv
hw/direct_mapped_cache.sv
hw/separate_caches.sv
hw/mem_arbiter.sv
hw/cache_subsystem_top.sv
test/tb_memory_model.sv
test/tb_cache_subsystem.sv

/* Bender.yml */
package:
  name: cache_subsystem

sources:
  - hw/cache_pkg.sv
  - hw/pass_through_cache.sv
  - hw/direct_mapped_cache.sv
  - hw/separate_caches.sv
  - hw/mem_arbiter.sv
  - hw/cache_subsystem_top.sv
  - target: test
    files:
      - test/tb_memory_model.sv
      - test/tb_cache_subsystem.sv
